// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_scratchpad_mem
RTL_TOP    ?= scratchpad_mem_top
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: common/spm_pkg.sv
package spm_pkg;

  // Memory organization
  localparam int unsigned SPM_NUM_BANKS  = 4;
  localparam int unsigned SPM_BANK_WORDS = 256;

  // Only the lower part of the bank space is usable
  localparam int unsigned SPM_NUM_WORDS  = 1000;

  // Data path
  localparam int unsigned SPM_DATA_W     = 32;
  localparam int unsigned SPM_BE_W       = SPM_DATA_W / 8;

  // Address split into bank index (high bits) and row (low bits)
  localparam int unsigned SPM_ROW_W      = $clog2(SPM_BANK_WORDS);
  localparam int unsigned SPM_BANK_IDX_W = $clog2(SPM_NUM_BANKS);
  localparam int unsigned SPM_ADDR_W     = SPM_BANK_IDX_W + SPM_ROW_W;

  // Word address over all banks
  typedef logic [SPM_ADDR_W-1:0]     spm_addr_t;

  // Row inside one bank
  typedef logic [SPM_ROW_W-1:0]      spm_row_t;

  // Bank number
  typedef logic [SPM_BANK_IDX_W-1:0] spm_bank_idx_t;

  // Data word
  typedef logic [SPM_DATA_W-1:0]     spm_data_t;

  // One enable per byte
  typedef logic [SPM_BE_W-1:0]       spm_be_t;

  // One bit per bank
  typedef logic [SPM_NUM_BANKS-1:0]  spm_bank_mask_t;

endpackage

// File: sram/sp_ram_bank.sv
`timescale 1ns/1ps

module sp_ram_bank (
  input  logic                    clk_i,
  input  spm_pkg::spm_bank_mask_t bank_sel_i,
  input  spm_pkg::spm_row_t       row_i,
  input  logic                    we_i,
  input  spm_pkg::spm_be_t        be_i,
  input  spm_pkg::spm_data_t      wdata_i,
  output spm_pkg::spm_data_t [spm_pkg::SPM_NUM_BANKS-1:0] bank_rdata_o
);

  // Active-low macro controls, one set per bank
  logic             [spm_pkg::SPM_NUM_BANKS-1:0] csn;
  logic             [spm_pkg::SPM_NUM_BANKS-1:0] wen;
  spm_pkg::spm_be_t [spm_pkg::SPM_NUM_BANKS-1:0] ben;

  genvar j;
  generate
    for (j = 0; j < spm_pkg::SPM_NUM_BANKS; j++)
    begin : g_bank

      // Unselected banks stay idle
      assign csn[j] = ~bank_sel_i[j];
      assign wen[j] = ~we_i;
      assign ben[j] = ~be_i;

      sram_macro u_macro (
        .clk_i ( clk_i           ),
        .csn_i ( csn[j]          ),
        .wen_i ( wen[j]          ),
        .ben_i ( ben[j]          ),
        .a_i   ( row_i           ),
        .d_i   ( wdata_i         ),
        .q_o   ( bank_rdata_o[j] )
      );

    end
  endgenerate

endmodule

// File: sram/sram_macro.sv
`timescale 1ns/1ps

module sram_macro (
  input  logic               clk_i,
  input  logic               csn_i,
  input  logic               wen_i,
  input  spm_pkg::spm_be_t   ben_i,
  input  spm_pkg::spm_row_t  a_i,
  input  spm_pkg::spm_data_t d_i,
  output spm_pkg::spm_data_t q_o
);

  spm_pkg::spm_data_t mem_q [spm_pkg::SPM_BANK_WORDS];

  // Write path, one byte lane per mask bit
  always_ff @(posedge clk_i)
  begin
    if (!csn_i && !wen_i)
    begin
      for (int unsigned b = 0; b < spm_pkg::SPM_BE_W; b++)
      begin
        if (!ben_i[b])
        begin
          mem_q[a_i][8*b +: 8] <= d_i[8*b +: 8];
        end
      end
    end
  end

  // Read path, output holds between reads
  always_ff @(posedge clk_i)
  begin
    if (!csn_i && wen_i)
    begin
      q_o <= mem_q[a_i];
    end
  end

endmodule

// File: src/mem_req_decode.sv
`timescale 1ns/1ps

module mem_req_decode (
  input  logic                   en_i,
  input  logic                   we_i,
  input  spm_pkg::spm_addr_t     addr_i,
  output spm_pkg::spm_bank_mask_t bank_sel_o,
  output spm_pkg::spm_row_t      row_o,
  output spm_pkg::spm_bank_idx_t bank_idx_o,
  output logic                   rd_o,
  output logic                   err_o
);

  logic out_of_range;
  logic req_ok;

  // Words past SPM_NUM_WORDS exist in the banks but are not mapped
  assign out_of_range = (addr_i >= spm_pkg::spm_addr_t'(spm_pkg::SPM_NUM_WORDS));

  assign req_ok = en_i && !out_of_range;

  // High bits pick the bank, low bits the row inside it
  assign bank_idx_o = addr_i[spm_pkg::SPM_ADDR_W-1 -: spm_pkg::SPM_BANK_IDX_W];
  assign row_o      = addr_i[spm_pkg::SPM_ROW_W-1:0];

  // One-hot select, empty when idle or rejected
  always_comb
  begin
    bank_sel_o = '0;
    for (int unsigned b = 0; b < spm_pkg::SPM_NUM_BANKS; b++)
    begin
      if (req_ok && (bank_idx_o == spm_pkg::spm_bank_idx_t'(b)))
      begin
        bank_sel_o[b] = 1'b1;
      end
    end
  end

  // Request kind
  assign rd_o  = req_ok && !we_i;
  assign err_o = en_i && out_of_range;

endmodule

// File: src/rdata_return.sv
`timescale 1ns/1ps

module rdata_return (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  spm_pkg::spm_bank_idx_t bank_idx_i,
  input  logic                   rd_i,
  input  logic                   err_i,
  input  spm_pkg::spm_data_t [spm_pkg::SPM_NUM_BANKS-1:0] bank_rdata_i,
  output spm_pkg::spm_data_t     rdata_o,
  output logic                   rvalid_o,
  output logic                   err_o
);

  spm_pkg::spm_bank_idx_t bank_idx_q;
  logic                   rd_q;
  logic                   err_q;
  spm_pkg::spm_data_t     rdata_sel;
  spm_pkg::spm_data_t     rdata_hold_q;

  // Track the request that is in flight
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bank_idx_q <= '0;
      rd_q       <= 1'b0;
      err_q      <= 1'b0;
    end
    else
    begin
      bank_idx_q <= bank_idx_i;
      rd_q       <= rd_i;
      err_q      <= err_i;
    end
  end

  // Rejected reads return zero
  assign rdata_sel = err_q ? '0 : bank_rdata_i[bank_idx_q];

  // Keep the last returned word between pulses
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rdata_hold_q <= '0;
    end
    else if (rd_q)
    begin
      rdata_hold_q <= rdata_sel;
    end
  end

  assign rdata_o  = rd_q ? rdata_sel : rdata_hold_q;
  assign rvalid_o = rd_q;
  assign err_o    = err_q;

endmodule

// File: src/scratchpad_mem_top.sv
`timescale 1ns/1ps

module scratchpad_mem_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               en_i,
  input  logic               we_i,
  input  spm_pkg::spm_addr_t addr_i,
  input  spm_pkg::spm_be_t   be_i,
  input  spm_pkg::spm_data_t wdata_i,
  output spm_pkg::spm_data_t rdata_o,
  output logic               rvalid_o,
  output logic               err_o
);

  spm_pkg::spm_bank_mask_t bank_sel;
  spm_pkg::spm_row_t       row;
  spm_pkg::spm_bank_idx_t  bank_idx;
  logic                    req_rd;
  logic                    req_err;
  spm_pkg::spm_data_t [spm_pkg::SPM_NUM_BANKS-1:0] bank_rdata;

  mem_req_decode u_decode (
    .en_i       ( en_i     ),
    .we_i       ( we_i     ),
    .addr_i     ( addr_i   ),
    .bank_sel_o ( bank_sel ),
    .row_o      ( row      ),
    .bank_idx_o ( bank_idx ),
    .rd_o       ( req_rd   ),
    .err_o      ( req_err  )
  );

  sp_ram_bank u_banks (
    .clk_i        ( clk_i      ),
    .bank_sel_i   ( bank_sel   ),
    .row_i        ( row        ),
    .we_i         ( we_i       ),
    .be_i         ( be_i       ),
    .wdata_i      ( wdata_i    ),
    .bank_rdata_o ( bank_rdata )
  );

  // A rejected read still owes a response, so it counts as a read here
  rdata_return u_return (
    .clk_i        ( clk_i                        ),
    .rst_ni       ( rst_ni                       ),
    .bank_idx_i   ( bank_idx                     ),
    .rd_i         ( req_rd | (req_err & ~we_i)   ),
    .err_i        ( req_err                      ),
    .bank_rdata_i ( bank_rdata                   ),
    .rdata_o      ( rdata_o                      ),
    .rvalid_o     ( rvalid_o                     ),
    .err_o        ( err_o                        )
  );

endmodule

// File: tb/tb_scratchpad_mem.sv
`timescale 1ns/1ps

module tb_scratchpad_mem;

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 2;
  localparam int SAMPLE_DELAY = 1;
  localparam int RESET_CYCLES = 10;
  localparam int RANDOM_REQS  = 200;

  // Request and idle cycles of each test in run order
  localparam int TEST_CYCLES  = 2 + 18 + 18 + 18 + 15 + (RANDOM_REQS + 2) + 13;
  localparam int MAX_CYCLES   = 2 * RESET_CYCLES + TEST_CYCLES + 100;

  logic               clk_i;
  logic               rst_ni;
  logic               en_i;
  logic               we_i;
  spm_pkg::spm_addr_t addr_i;
  spm_pkg::spm_be_t   be_i;
  spm_pkg::spm_data_t wdata_i;
  spm_pkg::spm_data_t rdata_o;
  logic               rvalid_o;
  logic               err_o;

  // Reference model of the mapped words
  spm_pkg::spm_data_t model_mem [spm_pkg::SPM_NUM_WORDS];
  bit                 written [spm_pkg::SPM_NUM_WORDS];
  spm_pkg::spm_addr_t written_addrs [$];
  spm_pkg::spm_data_t last_rdata;

  int     errors = 0;
  int     cycle_count = 0;
  integer seed;

  scratchpad_mem_top dut_i (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .en_i     ( en_i     ),
    .we_i     ( we_i     ),
    .addr_i   ( addr_i   ),
    .be_i     ( be_i     ),
    .wdata_i  ( wdata_i  ),
    .rdata_o  ( rdata_o  ),
    .rvalid_o ( rvalid_o ),
    .err_o    ( err_o    )
  );

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check_data(input string what, input spm_pkg::spm_data_t got,
                            input spm_pkg::spm_data_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Byte lanes with a set enable take the new data
  function automatic spm_pkg::spm_data_t merge_bytes(input spm_pkg::spm_data_t old_word,
                                                     input spm_pkg::spm_data_t new_word,
                                                     input spm_pkg::spm_be_t be);
    spm_pkg::spm_data_t res;
    res = old_word;
    for (int i = 0; i < spm_pkg::SPM_BE_W; i++)
    begin
      if (be[i])
      begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

  // First or last mapped row of a bank
  function automatic spm_pkg::spm_addr_t edge_addr(input int bank, input bit last_row);
    int word_addr;
    word_addr = bank * spm_pkg::SPM_BANK_WORDS;
    if (last_row)
    begin
      word_addr = word_addr + spm_pkg::SPM_BANK_WORDS - 1;
      if (word_addr >= spm_pkg::SPM_NUM_WORDS)
      begin
        word_addr = spm_pkg::SPM_NUM_WORDS - 1;
      end
    end
    return spm_pkg::spm_addr_t'(word_addr);
  endfunction

  task automatic drive_idle();
    en_i    = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    be_i    = '0;
    wdata_i = '0;
  endtask

  // Response of the request accepted at the coming edge
  task automatic expect_response(input string ctx, input logic exp_rvalid, input logic exp_err,
                                 input spm_pkg::spm_data_t exp_rdata);
    @(posedge clk_i);
    #SAMPLE_DELAY;
    check_flag({ctx, " rvalid_o"}, rvalid_o, exp_rvalid);
    check_flag({ctx, " err_o"}, err_o, exp_err);
    check_data({ctx, " rdata_o"}, rdata_o, exp_rdata);
    if (exp_rvalid)
    begin
      last_rdata = exp_rdata;
    end
    #(DRIVE_DELAY - SAMPLE_DELAY);
  endtask

  task automatic issue(input logic we, input spm_pkg::spm_addr_t addr,
                       input spm_pkg::spm_be_t be, input spm_pkg::spm_data_t wdata);
    logic               in_range;
    spm_pkg::spm_data_t exp_rdata;
    string              ctx;
    in_range  = int'(addr) < int'(spm_pkg::SPM_NUM_WORDS);
    ctx       = $sformatf("%s 0x%03h", we ? "write" : "read", addr);
    exp_rdata = last_rdata;
    if (!we)
    begin
      exp_rdata = in_range ? model_mem[addr] : '0;
    end
    else if (in_range)
    begin
      model_mem[addr] = merge_bytes(model_mem[addr], wdata, be);
      // A word is known once all its bytes were written
      if (!written[addr] && be == '1)
      begin
        written[addr] = 1'b1;
        written_addrs.push_back(addr);
      end
    end
    en_i    = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    expect_response(ctx, !we, !in_range, exp_rdata);
  endtask

  task automatic idle(input int cycles);
    drive_idle();
    repeat (cycles)
    begin
      expect_response("idle", 1'b0, 1'b0, last_rdata);
    end
  endtask

  task automatic apply_reset();
    drive_idle();
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni     = 1'b1;
    last_rdata = '0;
  endtask

  task automatic test_full_words();
    spm_pkg::spm_addr_t addr;
    for (int b = 0; b < spm_pkg::SPM_NUM_BANKS; b++)
    begin
      for (int r = 0; r < 2; r++)
      begin
        addr = edge_addr(b, r[0]);
        issue(1'b1, addr, '1, $random(seed));
        issue(1'b0, addr, '0, '0);
      end
    end
    idle(2);
  endtask

  task automatic test_byte_enables();
    spm_pkg::spm_be_t   be_list [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};
    spm_pkg::spm_addr_t addr;
    for (int k = 0; k < 2; k++)
    begin
      addr = (k == 0) ? written_addrs[0] : written_addrs[written_addrs.size() - 1];
      foreach (be_list[i])
      begin
        issue(1'b1, addr, be_list[i], $random(seed));
        issue(1'b0, addr, '0, '0);
      end
    end
    idle(2);
  endtask

  // Words of the first test lie two per bank, so this walks the banks in turn
  task automatic test_back_to_back();
    for (int i = 0; i < 16; i++)
    begin
      issue(1'b0, written_addrs[(i % 4) * 2 + (i / 4) % 2], '0, '0);
    end
    idle(2);
  endtask

  task automatic test_out_of_range();
    issue(1'b1, spm_pkg::spm_addr_t'(spm_pkg::SPM_NUM_WORDS), '1, 32'hdead_beef);
    issue(1'b0, '1, '0, '0);
    issue(1'b0, spm_pkg::spm_addr_t'(spm_pkg::SPM_NUM_WORDS), '0, '0);
    issue(1'b1, spm_pkg::spm_addr_t'(spm_pkg::SPM_NUM_WORDS + 15), 4'b0101, 32'h1234_5678);
    idle(1);
    foreach (written_addrs[i])
    begin
      issue(1'b0, written_addrs[i], '0, '0);
    end
    idle(2);
  endtask

  task automatic test_random_traffic();
    int unsigned        rnd;
    spm_pkg::spm_addr_t addr;
    spm_pkg::spm_be_t   be;
    for (int n = 0; n < RANDOM_REQS; n++)
    begin
      rnd = $random(seed);
      if (rnd[0] && written_addrs.size() > 0)
      begin
        addr = written_addrs[(rnd >> 1) % written_addrs.size()];
        issue(1'b0, addr, '0, '0);
      end
      else
      begin
        addr = spm_pkg::spm_addr_t'((rnd >> 1) % spm_pkg::SPM_NUM_WORDS);
        be   = spm_pkg::spm_be_t'(rnd >> 16);
        // Fresh words get a full write so no byte stays unknown
        if (!written[addr])
        begin
          be = '1;
        end
        issue(1'b1, addr, be, $random(seed));
      end
    end
    idle(2);
  endtask

  task automatic test_reset_and_idle();
    issue(1'b0, written_addrs[2], '0, '0);
    idle(5);
    apply_reset();
    idle(3);
    // Memory contents survive a reset
    issue(1'b0, written_addrs[3], '0, '0);
    idle(3);
  endtask

  initial
  begin
    seed = 32'h50c7;
    apply_reset();
    idle(2);
    test_full_words();
    test_byte_enables();
    test_back_to_back();
    test_out_of_range();
    test_random_traffic();
    test_reset_and_idle();
    $display("Errors: %0d", errors);
    if (errors == 0)
    begin
      $display("All checks passed");
    end
    else
    begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
common/spm_pkg.sv
src/mem_req_decode.sv
sram/sram_macro.sv
sram/sp_ram_bank.sv
src/rdata_return.sv
src/scratchpad_mem_top.sv
tb/tb_scratchpad_mem.sv
